// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@echo "TEST PASSED"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
cpu_pkg.sv
cpu_alu.sv
cpu_regfile.sv
cpu_bus_lanes.sv
cpu_datapath.sv
cpu_control.sv
cpu_top.sv
cpu_sva.sv
tb_mem.sv
tb_cpu.sv

// File: cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu import cpu_pkg::*; (
  input  logic [31:0] in1_i,
  input  logic [31:0] in2_i,
  input  alu_func_e   func_i,
  output logic [31:0] out_o,
  output logic        c_o,
  output logic        n_o,
  output logic        v_o,
  output logic        z_o
);

  logic [32:0] sum;
  logic [32:0] diff;

  assign sum  = {1'b0, in1_i} + {1'b0, in2_i};
  assign diff = {1'b0, in1_i} - {1'b0, in2_i}; // bit 32 is the borrow

  always_comb begin
    out_o = sum[31:0];
    c_o   = 1'b0;
    v_o   = 1'b0;
    case (func_i)
      ALU_ADD: begin
        out_o = sum[31:0];
        c_o   = sum[32];
        v_o   = (in1_i[31] == in2_i[31]) && (sum[31] != in1_i[31]);
      end
      ALU_SUB: begin
        out_o = diff[31:0];
        c_o   = diff[32];
        // signs differ and result flipped away from in1
        v_o   = (in1_i[31] != in2_i[31]) && (diff[31] != in1_i[31]);
      end
      ALU_AND: out_o = in1_i & in2_i;
      ALU_OR:  out_o = in1_i | in2_i;
      ALU_XOR: out_o = in1_i ^ in2_i;
      default: begin
        out_o = sum[31:0];
        c_o   = sum[32];
      end
    endcase
  end

  assign n_o = out_o[31];
  assign z_o = (out_o == 32'h0);

endmodule

// File: cpu_bus_lanes.sv
`timescale 1ns/1ps

module cpu_bus_lanes import cpu_pkg::*; (
  input  logic [1:0]  adr_lo_i,
  input  size_e       size_i,
  input  logic [31:0] mdr_i,
  input  logic [31:0] dat_i,
  output logic [3:0]  sel_o,
  output logic [31:0] dat_o,
  output logic [31:0] load_data_o
);

  logic [7:0] lane_byte;

  always_comb begin
    case (adr_lo_i)
      2'd0:    lane_byte = dat_i[7:0];
      2'd1:    lane_byte = dat_i[15:8];
      2'd2:    lane_byte = dat_i[23:16];
      default: lane_byte = dat_i[31:24];
    endcase
  end

  always_comb begin
    if (size_i == SIZE_BYTE) begin
      sel_o       = 4'b0001 << adr_lo_i; // one lane only
      dat_o       = {4{mdr_i[7:0]}};     // memory picks its lane via sel_o
      load_data_o = {24'h0, lane_byte};
    end else begin
      sel_o       = 4'b1111;
      dat_o       = mdr_i;
      load_data_o = dat_i;
    end
  end

endmodule

// File: cpu_control.sv
`timescale 1ns/1ps

module cpu_control import cpu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        ack_i,
  input  logic [31:0] ir_i,
  input  logic [2:0]  ccr_i,
  output pc_sel_e     pc_sel_o,
  output mar_sel_e    mar_sel_o,
  output mdr_sel_e    mdr_sel_o,
  output reg_sel_e    reg_sel_o,
  output alu2_sel_e   alu2_sel_o,
  output ccr_sel_e    ccr_sel_o,
  output alu_func_e   alu_func_o,
  output logic [3:0]  rd_addr1_o,
  output logic [3:0]  rd_addr2_o,
  output logic [3:0]  wr_addr_o,
  output logic        reg_write_o,
  output logic        ir_write_o,
  output logic        addr_sel_o,
  output size_e       size_o,
  output logic        cyc_o,
  output logic        we_o,
  output logic        halt_o
);

  state_e      state, state_next;
  opcode_e     op;
  logic [3:0]  ra, rb, rc;
  logic        cyc_next, we_next;
  logic        bus_done;
  logic        is_load, is_store, is_byte;
  logic        taken;

  assign op = opcode_e'(ir_i[OP_HI:OP_LO]);
  assign ra = ir_i[RA_HI:RA_LO];
  assign rb = ir_i[RB_HI:RB_LO];
  assign rc = ir_i[RC_HI:RC_LO];

  assign is_load  = (op == OP_LDW) || (op == OP_LDB);
  assign is_store = (op == OP_STW) || (op == OP_STB);
  assign is_byte  = (op == OP_LDB) || (op == OP_STB);
  assign bus_done = cyc_o && ack_i;

  always_comb begin
    case (op)
      OP_BEQ:  taken = ccr_i[0];
      OP_BNE:  taken = !ccr_i[0];
      OP_BLT:  taken = ccr_i[1];
      OP_JMP:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    state_next  = state;
    cyc_next    = cyc_o;
    we_next     = we_o;
    pc_sel_o    = PC_HOLD;
    mar_sel_o   = MAR_HOLD;
    mdr_sel_o   = MDR_HOLD;
    reg_sel_o   = REG_ALU;
    alu2_sel_o  = ALU2_REG;
    ccr_sel_o   = CCR_HOLD;
    alu_func_o  = ALU_ADD;
    rd_addr1_o  = rb;
    rd_addr2_o  = rc;
    wr_addr_o   = ra;
    reg_write_o = 1'b0;
    ir_write_o  = 1'b0;

    case (state)
      S_FETCH: begin
        if (!cyc_o) begin
          cyc_next = 1'b1;
        end else if (ack_i) begin
          cyc_next   = 1'b0;
          ir_write_o = 1'b1;
          pc_sel_o   = PC_PLUS4;
          state_next = S_DECODE;
        end
      end
      S_DECODE: begin
        case (op)
          OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LDI,
          OP_LDW, OP_LDB, OP_STW, OP_STB, OP_CMP, OP_BEQ, OP_BNE, OP_BLT,
          OP_JMP:  state_next = S_EXEC;
          default: state_next = S_HALTED; // HALT and unknown opcodes
        endcase
      end
      S_EXEC: begin
        state_next = S_FETCH;
        case (op)
          OP_ADD, OP_AND, OP_OR, OP_XOR: begin
            reg_write_o = 1'b1;
            case (op)
              OP_AND:  alu_func_o = ALU_AND;
              OP_OR:   alu_func_o = ALU_OR;
              OP_XOR:  alu_func_o = ALU_XOR;
              default: alu_func_o = ALU_ADD;
            endcase
          end
          OP_SUB: begin
            alu_func_o  = ALU_SUB;
            ccr_sel_o   = CCR_ALU;
            reg_write_o = 1'b1;
          end
          OP_CMP: begin
            alu_func_o = ALU_SUB; // flags only
            ccr_sel_o  = CCR_ALU;
          end
          OP_ADDI: begin
            alu2_sel_o  = ALU2_IMM;
            reg_write_o = 1'b1;
          end
          OP_LDI: begin
            reg_sel_o   = REG_IMM;
            reg_write_o = 1'b1;
          end
          OP_LDW, OP_LDB, OP_STW, OP_STB: state_next = S_MEM_ADDR;
          OP_BEQ, OP_BNE, OP_BLT, OP_JMP: begin
            if (taken) begin
              state_next = S_BRANCH;
            end
          end
          default: state_next = S_FETCH;
        endcase
      end
      S_MEM_ADDR: begin
        alu2_sel_o = ALU2_IMM; // rb + imm
        mar_sel_o  = MAR_ALU;
        rd_addr2_o = ra;       // store data
        mdr_sel_o  = MDR_REG;
        cyc_next   = 1'b1;
        we_next    = is_store;
        state_next = S_MEM;
      end
      S_MEM: begin
        if (bus_done) begin
          cyc_next   = 1'b0;
          we_next    = 1'b0;
          if (is_load) begin
            mdr_sel_o  = MDR_BUS;
            state_next = S_WRITEBACK;
          end else begin
            state_next = S_FETCH;
          end
        end
      end
      S_WRITEBACK: begin
        reg_sel_o   = REG_MDR;
        reg_write_o = 1'b1;
        state_next  = S_FETCH;
      end
      S_BRANCH: begin
        alu2_sel_o = ALU2_IMM;
        pc_sel_o   = (op == OP_JMP) ? PC_REG : PC_REL;
        state_next = S_FETCH;
      end
      default: state_next = S_HALTED; // stays until reset
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state <= S_FETCH;
      cyc_o <= 1'b0;
      we_o  <= 1'b0;
    end else begin
      state <= state_next;
      cyc_o <= cyc_next;
      we_o  <= we_next;
    end
  end

  assign addr_sel_o = (state == S_MEM);
  assign size_o     = (state == S_MEM && is_byte) ? SIZE_BYTE : SIZE_WORD;
  assign halt_o     = (state == S_HALTED);

endmodule

// File: cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath import cpu_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [31:0] dat_i,
  input  logic [31:0] load_data_i,
  input  logic [31:0] alu_out_i,
  input  logic        c_i,
  input  logic        n_i,
  input  logic        v_i,
  input  logic        z_i,
  input  logic [31:0] rd_data1_i,
  input  logic [31:0] rd_data2_i,
  input  pc_sel_e     pc_sel_i,
  input  mar_sel_e    mar_sel_i,
  input  mdr_sel_e    mdr_sel_i,
  input  reg_sel_e    reg_sel_i,
  input  alu2_sel_e   alu2_sel_i,
  input  ccr_sel_e    ccr_sel_i,
  input  logic        ir_write_i,
  input  logic        addr_sel_i,
  output logic [31:0] ir_o,
  output logic [2:0]  ccr_o,
  output logic [31:0] adr_o,
  output logic [31:0] mdr_o,
  output logic [31:0] alu_in1_o,
  output logic [31:0] alu_in2_o,
  output logic [31:0] reg_wdata_o
);

  logic [31:0] pc, pc_next;
  logic [31:0] ir;
  logic [31:0] mdr, mdr_next;
  logic [31:0] mar, mar_next;
  logic [2:0]  ccr, ccr_next;
  logic [31:0] imm;

  assign imm = {{16{ir[IMM_HI]}}, ir[IMM_HI:IMM_LO]};

  always_comb begin
    case (pc_sel_i)
      PC_PLUS4: pc_next = pc + 32'd4;
      PC_REL:   pc_next = pc + imm;   // pc already points past the branch
      PC_REG:   pc_next = alu_out_i;  // register plus offset
      default:  pc_next = pc;
    endcase

    case (mar_sel_i)
      MAR_ALU: mar_next = alu_out_i;
      default: mar_next = mar;
    endcase

    case (mdr_sel_i)
      MDR_BUS: mdr_next = load_data_i;
      MDR_REG: mdr_next = rd_data2_i;
      default: mdr_next = mdr;
    endcase

    case (ccr_sel_i)
      CCR_ALU: ccr_next = {c_i, n_i ^ v_i, z_i}; // carry, less-than, zero
      default: ccr_next = ccr;
    endcase

    case (reg_sel_i)
      REG_MDR: reg_wdata_o = mdr;
      REG_IMM: reg_wdata_o = imm;
      default: reg_wdata_o = alu_out_i;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      pc  <= RESET_PC;
      ir  <= 32'h0;
      mdr <= 32'h0;
      mar <= 32'h0;
      ccr <= 3'h0;
    end else begin
      pc  <= pc_next;
      mdr <= mdr_next;
      mar <= mar_next;
      ccr <= ccr_next;
      if (ir_write_i) begin
        ir <= dat_i;
      end
    end
  end

  assign alu_in1_o = rd_data1_i;
  assign alu_in2_o = (alu2_sel_i == ALU2_IMM) ? imm : rd_data2_i;

  assign adr_o = addr_sel_i ? mar : pc; // mar only for data cycles
  assign ir_o  = ir;
  assign ccr_o = ccr;
  assign mdr_o = mdr;

endmodule

// File: cpu_pkg.sv
package cpu_pkg;

  // instruction fields
  localparam int OP_HI  = 31;
  localparam int OP_LO  = 24;
  localparam int RA_HI  = 23;
  localparam int RA_LO  = 20;
  localparam int RB_HI  = 19;
  localparam int RB_LO  = 16;
  localparam int RC_HI  = 15;
  localparam int RC_LO  = 12;
  localparam int IMM_HI = 15;
  localparam int IMM_LO = 0;

  typedef enum logic [7:0] {
    OP_NOP  = 8'h00,
    OP_ADD  = 8'h01,
    OP_SUB  = 8'h02,
    OP_AND  = 8'h03,
    OP_OR   = 8'h04,
    OP_XOR  = 8'h05,
    OP_ADDI = 8'h06,
    OP_LDI  = 8'h07,
    OP_LDW  = 8'h08,
    OP_LDB  = 8'h09,
    OP_STW  = 8'h0a,
    OP_STB  = 8'h0b,
    OP_CMP  = 8'h0c,
    OP_BEQ  = 8'h0d,
    OP_BNE  = 8'h0e,
    OP_BLT  = 8'h0f,
    OP_JMP  = 8'h10,
    OP_HALT = 8'h11
  } opcode_e;

  typedef enum logic [2:0] {
    S_FETCH,
    S_DECODE,
    S_EXEC,
    S_MEM_ADDR,
    S_MEM,
    S_WRITEBACK,
    S_BRANCH,
    S_HALTED
  } state_e;

  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_func_e;

  typedef enum logic [1:0] {PC_HOLD, PC_PLUS4, PC_REL, PC_REG} pc_sel_e;
  typedef enum logic {MAR_HOLD, MAR_ALU} mar_sel_e;
  typedef enum logic [1:0] {MDR_HOLD, MDR_BUS, MDR_REG} mdr_sel_e;
  typedef enum logic [1:0] {REG_ALU, REG_MDR, REG_IMM} reg_sel_e;
  typedef enum logic {ALU2_REG, ALU2_IMM} alu2_sel_e;
  typedef enum logic {CCR_HOLD, CCR_ALU} ccr_sel_e;

  typedef enum logic {SIZE_WORD, SIZE_BYTE} size_e;

endpackage

// File: cpu_regfile.sv
`timescale 1ns/1ps

module cpu_regfile (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [3:0]  rd_addr1_i,
  input  logic [3:0]  rd_addr2_i,
  input  logic [3:0]  wr_addr_i,
  input  logic [31:0] wr_data_i,
  input  logic        wr_en_i,
  output logic [31:0] rd_data1_o,
  output logic [31:0] rd_data2_o
);

  logic [31:0] regs [16];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= 32'h0;
      end
    end else if (wr_en_i) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // read ports are combinational
  assign rd_data1_o = regs[rd_addr1_i];
  assign rd_data2_o = regs[rd_addr2_i];

endmodule

// File: cpu_sva.sv
`timescale 1ns/1ps

module cpu_sva import cpu_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input logic        clk_i,
  input logic        rst_i,
  input logic        cyc_i,
  input logic        we_i,
  input logic        ack_i,
  input logic        halt_i,
  input logic [31:0] adr_i,
  input logic [31:0] dat_i,
  input logic [3:0]  sel_i,
  input logic [7:0]  op_i
);

  logic fail_seen;
  logic seen_cyc;

  initial fail_seen = 1'b0;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) seen_cyc <= 1'b0;
    else if (cyc_i) seen_cyc <= 1'b1;
  end

  reset_quiet: assert property (@(posedge clk_i) rst_i |-> !cyc_i && !we_i && !halt_i)
    else begin
      fail_seen = 1'b1;
      $error("bus or halt active during reset");
    end

  first_fetch: assert property (@(posedge clk_i) disable iff (rst_i)
    cyc_i && !seen_cyc |-> adr_i == RESET_PC && !we_i)
    else begin
      fail_seen = 1'b1;
      $error("first fetch not at reset address");
    end

  bus_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    cyc_i && !ack_i |=> $stable(adr_i) && $stable(sel_i) && $stable(we_i) && $stable(dat_i))
    else begin
      fail_seen = 1'b1;
      $error("bus signals changed before ack");
    end

  // STW in ir while writing
  word_lanes: assert property (@(posedge clk_i) disable iff (rst_i)
    cyc_i && we_i && op_i == OP_STW |-> sel_i == 4'b1111)
    else begin
      fail_seen = 1'b1;
      $error("word store without all lanes");
    end

  byte_lanes: assert property (@(posedge clk_i) disable iff (rst_i)
    cyc_i && we_i && op_i == OP_STB |->
      $onehot(sel_i) && sel_i[adr_i[1:0]] && dat_i == {4{dat_i[7:0]}})
    else begin
      fail_seen = 1'b1;
      $error("byte store lanes wrong");
    end

  halt_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    halt_i |=> halt_i && !cyc_i)
    else begin
      fail_seen = 1'b1;
      $error("activity after halt");
    end

endmodule

bind cpu_top cpu_sva #(.RESET_PC(RESET_PC)) u_sva (
  .clk_i(clk_i), .rst_i(rst_i), .cyc_i(cyc_o), .we_i(we_o), .ack_i(ack_i),
  .halt_i(halt_o), .adr_i(adr_o), .dat_i(dat_o), .sel_i(sel_o), .op_i(ir[31:24]));

// File: cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        ack_i,
  input  logic [31:0] dat_i,
  output logic [31:0] adr_o,
  output logic [31:0] dat_o,
  output logic [3:0]  sel_o,
  output logic        cyc_o,
  output logic        we_o,
  output logic        halt_o
);

  pc_sel_e     pc_sel;
  mar_sel_e    mar_sel;
  mdr_sel_e    mdr_sel;
  reg_sel_e    reg_sel;
  alu2_sel_e   alu2_sel;
  ccr_sel_e    ccr_sel;
  alu_func_e   alu_func;
  size_e       size;
  logic        ir_write, addr_sel, reg_write;
  logic [3:0]  rd_addr1, rd_addr2, wr_addr;
  logic [31:0] ir, mdr, load_data, alu_out, alu_in1, alu_in2;
  logic [31:0] rd_data1, rd_data2, reg_wdata;
  logic [2:0]  ccr;
  logic        alu_c, alu_n, alu_v, alu_z;

  cpu_control u_control (
    .clk_i(clk_i), .rst_i(rst_i), .ack_i(ack_i), .ir_i(ir), .ccr_i(ccr),
    .pc_sel_o(pc_sel), .mar_sel_o(mar_sel), .mdr_sel_o(mdr_sel), .reg_sel_o(reg_sel),
    .alu2_sel_o(alu2_sel), .ccr_sel_o(ccr_sel), .alu_func_o(alu_func),
    .rd_addr1_o(rd_addr1), .rd_addr2_o(rd_addr2), .wr_addr_o(wr_addr),
    .reg_write_o(reg_write), .ir_write_o(ir_write), .addr_sel_o(addr_sel),
    .size_o(size), .cyc_o(cyc_o), .we_o(we_o), .halt_o(halt_o));

  cpu_datapath #(.RESET_PC(RESET_PC)) u_datapath (
    .clk_i(clk_i), .rst_i(rst_i), .dat_i(dat_i), .load_data_i(load_data),
    .alu_out_i(alu_out), .c_i(alu_c), .n_i(alu_n), .v_i(alu_v), .z_i(alu_z),
    .rd_data1_i(rd_data1), .rd_data2_i(rd_data2), .pc_sel_i(pc_sel), .mar_sel_i(mar_sel),
    .mdr_sel_i(mdr_sel), .reg_sel_i(reg_sel), .alu2_sel_i(alu2_sel), .ccr_sel_i(ccr_sel),
    .ir_write_i(ir_write), .addr_sel_i(addr_sel), .ir_o(ir), .ccr_o(ccr), .adr_o(adr_o),
    .mdr_o(mdr), .alu_in1_o(alu_in1), .alu_in2_o(alu_in2), .reg_wdata_o(reg_wdata));

  cpu_alu u_alu (
    .in1_i(alu_in1), .in2_i(alu_in2), .func_i(alu_func), .out_o(alu_out),
    .c_o(alu_c), .n_o(alu_n), .v_o(alu_v), .z_o(alu_z));

  cpu_regfile u_regfile (
    .clk_i(clk_i), .rst_i(rst_i), .rd_addr1_i(rd_addr1), .rd_addr2_i(rd_addr2),
    .wr_addr_i(wr_addr), .wr_data_i(reg_wdata), .wr_en_i(reg_write),
    .rd_data1_o(rd_data1), .rd_data2_o(rd_data2));

  cpu_bus_lanes u_bus_lanes (
    .adr_lo_i(adr_o[1:0]), .size_i(size), .mdr_i(mdr), .dat_i(dat_i),
    .sel_o(sel_o), .dat_o(dat_o), .load_data_o(load_data));

endmodule

// File: tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

  logic        clk_i;
  logic        rst_i;
  logic        ack_i;
  logic [31:0] dat_i;
  logic [31:0] adr_o, dat_o;
  logic [3:0]  sel_o;
  logic        cyc_o, we_o, halt_o;
  logic        mem_err;

  logic [31:0] rand_state;
  logic [15:0] a1, a2, b1, b2;
  logic [31:0] a, b, fill;
  logic        a_lt_b;
  int          want_hits;
  int          cycles;

  cpu_top #(.RESET_PC(32'h0)) uut (
    .clk_i(clk_i), .rst_i(rst_i), .ack_i(ack_i), .dat_i(dat_i), .adr_o(adr_o),
    .dat_o(dat_o), .sel_o(sel_o), .cyc_o(cyc_o), .we_o(we_o), .halt_o(halt_o));

  tb_mem u_mem (
    .clk_i(clk_i), .rst_i(rst_i), .cyc_i(cyc_o), .we_i(we_o), .adr_i(adr_o),
    .sel_i(sel_o), .dat_i(dat_o), .ack_o(ack_i), .dat_o(dat_i), .err_o(mem_err));

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] enc(input opcode_e op, input logic [3:0] ra,
                                      input logic [3:0] rb, input logic [15:0] imm);
    return {op, ra, rb, imm};
  endfunction

  function automatic logic [31:0] sext(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  task automatic expect_word(input logic [31:0] addr, input logic [31:0] value);
    u_mem.exp_kind[addr[9:2]] = 2'd1;
    u_mem.exp_data[addr[9:2]] = value;
    want_hits++;
  endtask

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_flags();
    if (mem_err || uut.u_sva.fail_seen) stop_with_failure("a check failed, see above");
  endtask

  initial begin
    rst_i     = 1'b1;
    want_hits = 0;
    rand_state = 32'h856c_d59a;
    rand_state = lcg_step(rand_state);
    a1 = rand_state[31:16];
    rand_state = lcg_step(rand_state);
    a2 = rand_state[31:16];
    rand_state = lcg_step(rand_state);
    b1 = rand_state[31:16];
    rand_state = lcg_step(rand_state);
    b2 = rand_state[31:16];
    a      = sext(a1) + sext(a2);
    b      = sext(b1) + sext(b2);
    a_lt_b = $signed(a) < $signed(b);

    for (int i = 0; i < 256; i++) begin
      u_mem.mem[i]      = 32'h9e37_79b9 * (i + 1); // distinct per word
      u_mem.exp_kind[i] = 2'd0;
      u_mem.exp_data[i] = 32'h0;
    end
    fill = u_mem.mem[136]; // word 0x220 before the byte store

    u_mem.mem[0]  = enc(OP_LDI, 4'd1, 4'd0, a1);
    u_mem.mem[1]  = enc(OP_ADDI, 4'd1, 4'd1, a2);
    u_mem.mem[2]  = enc(OP_LDI, 4'd2, 4'd0, b1);
    u_mem.mem[3]  = enc(OP_ADDI, 4'd2, 4'd2, b2);
    u_mem.mem[4]  = enc(OP_ADD, 4'd3, 4'd1, 16'h2000);
    u_mem.mem[5]  = enc(OP_STW, 4'd3, 4'd0, 16'h0200);
    u_mem.mem[6]  = enc(OP_SUB, 4'd4, 4'd1, 16'h2000);
    u_mem.mem[7]  = enc(OP_STW, 4'd4, 4'd0, 16'h0204);
    u_mem.mem[8]  = enc(OP_AND, 4'd5, 4'd1, 16'h2000);
    u_mem.mem[9]  = enc(OP_STW, 4'd5, 4'd0, 16'h0208);
    u_mem.mem[10] = enc(OP_OR, 4'd6, 4'd1, 16'h2000);
    u_mem.mem[11] = enc(OP_STW, 4'd6, 4'd0, 16'h020c);
    u_mem.mem[12] = enc(OP_XOR, 4'd7, 4'd1, 16'h2000);
    u_mem.mem[13] = enc(OP_STW, 4'd7, 4'd0, 16'h0210);
    u_mem.mem[14] = enc(OP_STB, 4'd1, 4'd0, 16'h0221);
    u_mem.mem[15] = enc(OP_LDW, 4'd8, 4'd0, 16'h0220);
    u_mem.mem[16] = enc(OP_STW, 4'd8, 4'd0, 16'h0214);
    u_mem.mem[17] = enc(OP_LDB, 4'd9, 4'd0, 16'h0221);
    u_mem.mem[18] = enc(OP_STW, 4'd9, 4'd0, 16'h0218);
    u_mem.mem[19] = enc(OP_LDI, 4'd10, 4'd0, 16'h5a5a);
    u_mem.mem[20] = enc(OP_NOP, 4'd0, 4'd0, 16'h0000);
    u_mem.mem[21] = enc(OP_CMP, 4'd0, 4'd1, 16'h1000); // r1 minus r1 sets zero
    u_mem.mem[22] = enc(OP_BEQ, 4'd0, 4'd0, 16'h0004);
    u_mem.mem[23] = enc(OP_STW, 4'd10, 4'd0, 16'h0230);
    u_mem.mem[24] = enc(OP_BNE, 4'd0, 4'd0, 16'h0004);
    u_mem.mem[25] = enc(OP_STW, 4'd10, 4'd0, 16'h0234);
    u_mem.mem[26] = enc(OP_CMP, 4'd0, 4'd1, 16'h2000);
    u_mem.mem[27] = enc(OP_BLT, 4'd0, 4'd0, 16'h0004);
    u_mem.mem[28] = enc(OP_STW, 4'd10, 4'd0, 16'h0238);
    u_mem.mem[29] = enc(OP_JMP, 4'd0, 4'd0, 16'h007c); // to the halt at 0x7c
    u_mem.mem[30] = enc(OP_STW, 4'd10, 4'd0, 16'h023c);
    u_mem.mem[31] = enc(OP_HALT, 4'd0, 4'd0, 16'h0000);

    expect_word(32'h200, a + b);
    expect_word(32'h204, a - b);
    expect_word(32'h208, a & b);
    expect_word(32'h20c, a | b);
    expect_word(32'h210, a ^ b);
    expect_word(32'h220, {fill[31:16], a[7:0], fill[7:0]});
    expect_word(32'h214, {fill[31:16], a[7:0], fill[7:0]});
    expect_word(32'h218, {24'h0, a[7:0]});
    expect_word(32'h234, 32'h0000_5a5a);
    if (a_lt_b) u_mem.exp_kind[142] = 2'd2;
    else expect_word(32'h238, 32'h0000_5a5a);
    u_mem.exp_kind[140] = 2'd2; // 0x230
    u_mem.exp_kind[143] = 2'd2; // 0x23c

    repeat (8) @(posedge clk_i);
    #1 rst_i = 1'b0;

    cycles = 0;
    while (!halt_o && cycles < 5000) begin
      @(posedge clk_i);
      #2;
      check_flags();
      cycles++;
    end
    if (!halt_o) stop_with_failure("timeout: halt_o never rose");

    // halt must hold with the bus idle
    repeat (20) begin
      @(posedge clk_i);
      #2;
      check_flags();
    end

    if (u_mem.hits != want_hits) begin
      $display("** Error at %0t: %0d expected stores seen, wanted %0d", $time,
               u_mem.hits, want_hits);
      $display("Finished with errors");
      $fatal(1);
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

// File: tb_mem.sv
`timescale 1ns/1ps

module tb_mem #(
  parameter logic [31:0] SEED = 32'h856c_d59a
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        cyc_i,
  input  logic        we_i,
  input  logic [31:0] adr_i,
  input  logic [3:0]  sel_i,
  input  logic [31:0] dat_i,
  output logic        ack_o,
  output logic [31:0] dat_o,
  output logic        err_o
);

  logic [31:0] mem [256];
  logic [31:0] exp_data [256];
  logic [1:0]  exp_kind [256]; // 0 any, 1 expect exp_data, 2 must stay untouched
  int          hits;

  logic [31:0] rand_state;
  logic        busy;
  int          wait_cnt;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // apply byte lanes, then compare with the expected word
  task automatic write_word(input logic [7:0] idx);
    logic [31:0] w;
    w = mem[idx];
    for (int i = 0; i < 4; i++) begin
      if (sel_i[i]) w[8*i +: 8] = dat_i[8*i +: 8];
    end
    mem[idx] = w;
    if (exp_kind[idx] == 2'd2) begin
      assert (1'b0) else begin
        $display("** Error at %0t: store to skipped marker address %h", $time, adr_i);
        err_o = 1'b1;
      end
    end else if (exp_kind[idx] == 2'd1) begin
      assert (w == exp_data[idx]) else begin
        $display("** Error at %0t: word %h is %h, expected %h", $time, adr_i, w,
                 exp_data[idx]);
        err_o = 1'b1;
      end
      hits++;
    end
  endtask

  initial begin
    ack_o      = 1'b0;
    dat_o      = 32'h0;
    err_o      = 1'b0;
    hits       = 0;
    busy       = 1'b0;
    wait_cnt   = 0;
    rand_state = SEED;
    forever begin
      @(posedge clk_i);
      #1;
      if (ack_o) begin
        ack_o = 1'b0;
        busy  = 1'b0;
      end else if (cyc_i && !rst_i) begin
        if (!busy) begin
          busy       = 1'b1;
          rand_state = lcg_step(rand_state);
          wait_cnt   = int'(rand_state[17:16]); // 0 to 3 cycles
        end
        if (wait_cnt == 0) begin
          ack_o = 1'b1;
          dat_o = mem[adr_i[9:2]];
          if (we_i) write_word(adr_i[9:2]);
        end else begin
          wait_cnt--;
        end
      end
    end
  end

endmodule
